/* src.f */
+incdir+design
design/bus_pkg.sv
design/bus_arbiter.sv
design/bus_xbar.sv
design/clint_timer.sv
design/axi_lite_master.sv
design/core_bus.sv
bench/tb_core_bus.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and decide from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_core_bus -o tb_core_bus \
	> build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/tb_core_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0

/* bench/tb_core_bus.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bus_params.svh"

module tb_core_bus
	import bus_pkg::*;
();

	localparam int CYC   = 10;
	localparam int N_TXN = 410;

	logic       clock;
	logic       rst_i;
	logic       inst_valid_i;
	logic [31:0] inst_addr_i;
	logic       inst_ready_o;
	logic       inst_rsp_valid_o;
	bus_rsp_t   inst_rsp_o;
	logic       data_valid_i;
	bus_req_t   data_req_i;
	logic       data_ready_o;
	logic       data_rsp_valid_o;
	bus_rsp_t   data_rsp_o;
	logic       awvalid_o;
	axi_addr_t  aw_o;
	logic       awready_i;
	logic       wvalid_o;
	axi_wdata_t w_o;
	logic       wready_i;
	logic       bvalid_i;
	logic [1:0] bresp_i;
	logic       bready_o;
	logic       arvalid_o;
	axi_addr_t  ar_o;
	logic       arready_i;
	logic       rvalid_i;
	axi_rdata_t r_i;
	logic       rready_o;

	logic [31:0] rng;
	logic [31:0] mem [256];
	logic [31:0] ref_mem [256];
	longint      edge_cnt;
	int          errors;
	int          n_acc_data;
	int          n_acc_inst;
	int          n_rsp_data;
	int          n_rsp_inst;
	time         data_rsp_t;
	time         inst_rsp_t;
	xfer_size_e  exp_size;

	core_bus DUT (.*);

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	// pattern built from the full byte address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {~addr[15:0], addr[15:0]} ^ {addr[31:16], 16'h5A5A};
	endfunction

	initial begin
		clock = 1'b0;
		forever #(CYC / 2) clock = ~clock;
	end

	always @(posedge clock) begin
		if (rst_i) begin
			edge_cnt <= 0;
		end else begin
			edge_cnt <= edge_cnt + 1;
		end
	end

	// every pulse counted, checked against accepts at the end
	always @(negedge clock) begin
		if (data_rsp_valid_o) begin
			n_rsp_data++;
		end
		if (inst_rsp_valid_o) begin
			n_rsp_inst++;
		end
	end

	task automatic data_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strb, input xfer_size_e size, output bus_rsp_t rsp,
			output int lat, output longint snap);
		int n;
		data_req_i.addr  = addr;
		data_req_i.wdata = wdata;
		data_req_i.wstrb = strb;
		data_req_i.size  = size;
		data_req_i.we    = we;
		data_valid_i     = 1'b1;
		n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (!data_ready_o && n < 200);
		if (!data_ready_o) begin
			errors++;
			$display("data port never became ready for address %h", addr);
		end
		snap = edge_cnt;
		@(posedge clock);
		#1 data_valid_i = 1'b0;
		exp_size = size;
		n_acc_data++;
		lat = 0;
		do begin
			@(negedge clock);
			lat++;
		end while (!data_rsp_valid_o && lat < 200);
		if (!data_rsp_valid_o) begin
			errors++;
			$display("no data response for address %h", addr);
		end
		rsp = data_rsp_o;
		data_rsp_t = $time;
		@(posedge clock);
		#1;
	endtask

	task automatic fetch(input logic [31:0] addr, output bus_rsp_t rsp);
		int n;
		inst_addr_i  = addr;
		inst_valid_i = 1'b1;
		n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (!inst_ready_o && n < 400);
		if (!inst_ready_o) begin
			errors++;
			$display("fetch port never became ready for address %h", addr);
		end
		@(posedge clock);
		#1 inst_valid_i = 1'b0;
		exp_size = SZ_WORD;
		n_acc_inst++;
		n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (!inst_rsp_valid_o && n < 200);
		if (!inst_rsp_valid_o) begin
			errors++;
			$display("no fetch response for address %h", addr);
		end
		rsp = inst_rsp_o;
		inst_rsp_t = $time;
		@(posedge clock);
		#1;
	endtask

	// AXI4-Lite slave, handshakes sampled at negedge and applied after the edge
	initial begin
		logic        aw_f, w_f, ar_f, b_f, r_f, aw_seen, ar_seen;
		logic        have_aw, have_w;
		logic [31:0] aw_addr, w_data, ar_addr;
		logic [3:0]  w_strb;
		int          aw_dly, w_dly, ar_dly;
		have_aw = 0;
		have_w  = 0;
		aw_dly  = 0;
		w_dly   = 0;
		ar_dly  = 0;
		forever begin
			@(negedge clock);
			aw_f    = awvalid_o && awready_i;
			w_f     = wvalid_o && wready_i;
			ar_f    = arvalid_o && arready_i;
			b_f     = bvalid_i && bready_o;
			r_f     = rvalid_i && rready_o;
			aw_seen = awvalid_o;
			ar_seen = arvalid_o;
			// size follows the request that was accepted
			if (aw_f && aw_o.size !== exp_size) begin
				errors++;
				$display("MISMATCH aw_o.size got %h expected %h", aw_o.size, exp_size);
			end
			if (ar_f && ar_o.size !== exp_size) begin
				errors++;
				$display("MISMATCH ar_o.size got %h expected %h", ar_o.size, exp_size);
			end
			if (aw_f) aw_addr = aw_o.addr;
			if (ar_f) ar_addr = ar_o.addr;
			if (w_f) begin
				w_data = w_o.data;
				w_strb = w_o.strb;
			end
			@(posedge clock);
			#1;
			if (aw_f) begin
				have_aw   = 1;
				awready_i = 1'b0;
				aw_dly    = int'(xorshift32() & 32'h3);
			end else if (aw_seen && !awready_i) begin
				if (aw_dly == 0) awready_i = 1'b1;
				else aw_dly--;
			end
			if (w_f) begin
				have_w   = 1;
				wready_i = 1'b0;
				w_dly    = int'(xorshift32() & 32'h3);
			end else if (wvalid_o && !wready_i) begin
				if (w_dly == 0) wready_i = 1'b1;
				else w_dly--;
			end
			if (b_f) bvalid_i = 1'b0;
			if (have_aw && have_w && !bvalid_i) begin
				if (aw_addr < 32'h8000_0000) begin
					for (int b = 0; b < 4; b++) begin
						if (w_strb[b]) mem[aw_addr[9:2]][b*8 +: 8] = w_data[b*8 +: 8];
					end
					bresp_i = `AXI_RESP_OKAY;
				end else begin
					bresp_i = `AXI_RESP_SLVERR;
				end
				bvalid_i = 1'b1;
				have_aw  = 0;
				have_w   = 0;
			end
			if (r_f) rvalid_i = 1'b0;
			if (ar_f) begin
				arready_i = 1'b0;
				ar_dly    = int'(xorshift32() & 32'h3);
				r_i.data  = (ar_addr < 32'h8000_0000) ? mem[ar_addr[9:2]] : 32'h0;
				r_i.resp  = (ar_addr < 32'h8000_0000) ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
				rvalid_i  = 1'b1;
			end else if (ar_seen && !arready_i) begin
				if (ar_dly == 0) arready_i = 1'b1;
				else ar_dly--;
			end
		end
	end

	initial begin
		#(CYC * 200 * N_TXN);
		$display("watchdog expired, the bus stopped answering");
		$display("Regression failed");
		$finish;
	end

	initial begin
		bus_rsp_t    rsp, rsp2;
		logic [31:0] r, addr, wdata;
		logic [3:0]  strb;
		logic [7:0]  idx;
		xfer_size_e  size;
		int          lat, base;
		longint      snap, exp_t;
		rst_i = 1'b1;
		inst_valid_i = 1'b0;
		inst_addr_i = '0;
		data_valid_i = 1'b0;
		data_req_i = '0;
		awready_i = 1'b0;
		wready_i = 1'b0;
		bvalid_i = 1'b0;
		bresp_i = 2'b00;
		arready_i = 1'b0;
		rvalid_i = 1'b0;
		r_i = '0;
		rng = 32'd21;
		errors = 0;
		n_acc_data = 0;
		n_acc_inst = 0;
		n_rsp_data = 0;
		n_rsp_inst = 0;
		exp_size = SZ_WORD;
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(i * 4);
			ref_mem[i] = fill_word(i * 4);
		end
		repeat (4) @(posedge clock);
		#1 rst_i = 1'b0;

		@(negedge clock);
		if (inst_rsp_valid_o || data_rsp_valid_o || awvalid_o || wvalid_o || arvalid_o ||
				bready_o || rready_o) begin
			errors++;
			$display("a valid or ready output is high after reset");
		end
		$display("test 1 reset values: %0d errors", errors);
		@(posedge clock);
		#1;

		base = errors;
		for (int i = 0; i < 200; i++) begin
			r = xorshift32();
			idx = r[9:2];
			wdata = xorshift32();
			case (r[12:11])
				2'd0: begin
					size = SZ_BYTE;
					addr = {22'h0, idx, r[14:13]};
					strb = 4'b0001 << r[14:13];
				end
				2'd1: begin
					size = SZ_HALF;
					addr = {22'h0, idx, r[13], 1'b0};
					strb = r[13] ? 4'b1100 : 4'b0011;
				end
				default: begin
					size = SZ_WORD;
					addr = {22'h0, idx, 2'b00};
					strb = 4'b1111;
				end
			endcase
			data_access(r[0], addr, wdata, strb, size, rsp, lat, snap);
			if (rsp.err !== 1'b0) begin
				errors++;
				$display("MISMATCH err got %h expected %h", rsp.err, 1'b0);
			end
			if (r[0]) begin
				for (int b = 0; b < 4; b++) begin
					if (strb[b]) ref_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
				end
			end else if (rsp.rdata !== ref_mem[idx]) begin
				errors++;
				$display("MISMATCH rdata got %h expected %h", rsp.rdata, ref_mem[idx]);
			end
		end
		$display("test 2 axi data writes and reads: %0d errors", errors - base);

		base = errors;
		for (int i = 0; i < 100; i++) begin
			r = xorshift32();
			idx = r[9:2];
			if (r[16]) begin
				fork
					fetch({22'h0, idx, 2'b00}, rsp);
					data_access(1'b0, {22'h0, r[23:16], 2'b00}, 32'h0, 4'h0, SZ_WORD,
						rsp2, lat, snap);
				join
				if (rsp2.rdata !== ref_mem[r[23:16]]) begin
					errors++;
					$display("MISMATCH rdata got %h expected %h", rsp2.rdata, ref_mem[r[23:16]]);
				end
				if (data_rsp_t >= inst_rsp_t) begin
					errors++;
					$display("fetch response came before the data response");
				end
			end else begin
				fetch({22'h0, idx, 2'b00}, rsp);
			end
			if (rsp.rdata !== ref_mem[idx] || rsp.err !== 1'b0) begin
				errors++;
				$display("MISMATCH inst_rsp got %h expected %h", rsp, {ref_mem[idx], 1'b0});
			end
		end
		$display("test 3 fetches and priority: %0d errors", errors - base);

		base = errors;
		for (int i = 0; i < 4; i++) begin
			addr = `CLINT_BASE + ((i % 2) ? `CLINT_MTIME_HI : `CLINT_MTIME_LO);
			data_access(1'b0, addr, 32'h0, 4'h0, SZ_WORD, rsp, lat, snap);
			// count includes the accepting edge
			exp_t = snap + 1;
			if (rsp.rdata !== ((i % 2) ? exp_t[63:32] : exp_t[31:0])) begin
				errors++;
				$display("MISMATCH mtime got %h expected %h", rsp.rdata,
					((i % 2) ? exp_t[63:32] : exp_t[31:0]));
			end
			// seen in the second cycle after the accepting edge
			if (lat != 2) begin
				errors++;
				$display("clint response came %0d cycles after accept, not 2", lat);
			end
		end
		data_access(1'b1, `CLINT_BASE + `CLINT_MTIME_LO, 32'h1234, 4'hF, SZ_WORD, rsp, lat, snap);
		if (rsp.err !== 1'b1) begin
			errors++;
			$display("MISMATCH err got %h expected %h", rsp.err, 1'b1);
		end
		$display("test 4 clint timer: %0d errors", errors - base);

		base = errors;
		data_access(1'b1, 32'h8000_0010, 32'hDEAD_BEEF, 4'hF, SZ_WORD, rsp, lat, snap);
		if (rsp.err !== 1'b1) begin
			errors++;
			$display("MISMATCH err got %h expected %h", rsp.err, 1'b1);
		end
		data_access(1'b0, 32'h8000_0010, 32'h0, 4'h0, SZ_WORD, rsp, lat, snap);
		if (rsp.err !== 1'b1) begin
			errors++;
			$display("MISMATCH err got %h expected %h", rsp.err, 1'b1);
		end
		data_access(1'b0, 32'h0000_0040, 32'h0, 4'h0, SZ_WORD, rsp, lat, snap);
		if (rsp.rdata !== ref_mem[16] || rsp.err !== 1'b0) begin
			errors++;
			$display("MISMATCH rsp got %h expected %h", rsp, {ref_mem[16], 1'b0});
		end
		$display("test 5 slave errors: %0d errors", errors - base);

		base = errors;
		repeat (4) @(posedge clock);
		if (n_rsp_data != n_acc_data || n_rsp_inst != n_acc_inst) begin
			errors++;
			$display("response count differs from accepted requests: data %0d/%0d fetch %0d/%0d",
				n_rsp_data, n_acc_data, n_rsp_inst, n_acc_inst);
		end
		$display("test 6 one response per request: %0d errors", errors - base);

		$display("summary: 6 tests, %0d data and %0d fetch requests, %0d errors",
			n_acc_data, n_acc_inst, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/core_bus.sv */
`timescale 1ns/100ps
`default_nettype none

module core_bus
	import bus_pkg::*;
(
	input  wire                    clock,
	input  wire                    rst_i,
	input  wire                    inst_valid_i,
	input  wire [31:0]             inst_addr_i,
	output logic                   inst_ready_o,
	output logic                   inst_rsp_valid_o,
	output bus_rsp_t               inst_rsp_o,
	input  wire                    data_valid_i,
	input  bus_req_t               data_req_i,
	output logic                   data_ready_o,
	output logic                   data_rsp_valid_o,
	output bus_rsp_t               data_rsp_o,
	output logic                   awvalid_o,
	output axi_addr_t              aw_o,
	input  wire                    awready_i,
	output logic                   wvalid_o,
	output axi_wdata_t             w_o,
	input  wire                    wready_i,
	input  wire                    bvalid_i,
	input  wire [1:0]              bresp_i,
	output logic                   bready_o,
	output logic                   arvalid_o,
	output axi_addr_t              ar_o,
	input  wire                    arready_i,
	input  wire                    rvalid_i,
	input  axi_rdata_t             r_i,
	output logic                   rready_o
);

	bus_req_t inst_req;
	bus_req_t xreq;
	bus_rsp_t rsp;
	bus_rsp_t xrsp;
	bus_rsp_t clint_rsp;
	bus_rsp_t axi_rsp;
	logic     xreq_valid;
	logic     xreq_ready;
	logic     xrsp_valid;
	logic     clint_valid;
	logic     clint_ready;
	logic     clint_rsp_valid;
	logic     axi_valid;
	logic     axi_ready;
	logic     axi_rsp_valid;

	// fetch is a plain word read
	assign inst_req.addr  = inst_addr_i;
	assign inst_req.wdata = '0;
	assign inst_req.wstrb = '0;
	assign inst_req.size  = SZ_WORD;
	assign inst_req.we    = 1'b0;

	assign inst_rsp_o = rsp;
	assign data_rsp_o = rsp;

	bus_arbiter u_arbiter (
		.clock            (clock),
		.rst_i            (rst_i),
		.inst_valid_i     (inst_valid_i),
		.inst_req_i       (inst_req),
		.inst_ready_o     (inst_ready_o),
		.inst_rsp_valid_o (inst_rsp_valid_o),
		.data_valid_i     (data_valid_i),
		.data_req_i       (data_req_i),
		.data_ready_o     (data_ready_o),
		.data_rsp_valid_o (data_rsp_valid_o),
		.rsp_o            (rsp),
		.xreq_valid_o     (xreq_valid),
		.xreq_o           (xreq),
		.xreq_ready_i     (xreq_ready),
		.xrsp_valid_i     (xrsp_valid),
		.xrsp_i           (xrsp)
	);

	bus_xbar u_xbar (
		.clock             (clock),
		.rst_i             (rst_i),
		.req_valid_i       (xreq_valid),
		.req_i             (xreq),
		.req_ready_o       (xreq_ready),
		.rsp_valid_o       (xrsp_valid),
		.rsp_o             (xrsp),
		.clint_valid_o     (clint_valid),
		.clint_ready_i     (clint_ready),
		.clint_rsp_valid_i (clint_rsp_valid),
		.clint_rsp_i       (clint_rsp),
		.axi_valid_o       (axi_valid),
		.axi_ready_i       (axi_ready),
		.axi_rsp_valid_i   (axi_rsp_valid),
		.axi_rsp_i         (axi_rsp)
	);

	clint_timer u_clint (
		.clock       (clock),
		.rst_i       (rst_i),
		.req_valid_i (clint_valid),
		.req_i       (xreq),
		.req_ready_o (clint_ready),
		.rsp_valid_o (clint_rsp_valid),
		.rsp_o       (clint_rsp)
	);

	axi_lite_master u_axi (
		.clock       (clock),
		.rst_i       (rst_i),
		.req_valid_i (axi_valid),
		.req_i       (xreq),
		.req_ready_o (axi_ready),
		.rsp_valid_o (axi_rsp_valid),
		.rsp_o       (axi_rsp),
		.awvalid_o   (awvalid_o),
		.aw_o        (aw_o),
		.awready_i   (awready_i),
		.wvalid_o    (wvalid_o),
		.w_o         (w_o),
		.wready_i    (wready_i),
		.bvalid_i    (bvalid_i),
		.bresp_i     (bresp_i),
		.bready_o    (bready_o),
		.arvalid_o   (arvalid_o),
		.ar_o        (ar_o),
		.arready_i   (arready_i),
		.rvalid_i    (rvalid_i),
		.r_i         (r_i),
		.rready_o    (rready_o)
	);

endmodule

`default_nettype wire

/* design/axi_lite_master.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bus_params.svh"

module axi_lite_master
	import bus_pkg::*;
(
	input  wire        clock,
	input  wire        rst_i,
	input  wire        req_valid_i,
	input  bus_req_t   req_i,
	output logic       req_ready_o,
	output logic       rsp_valid_o,
	output bus_rsp_t   rsp_o,
	output logic       awvalid_o,
	output axi_addr_t  aw_o,
	input  wire        awready_i,
	output logic       wvalid_o,
	output axi_wdata_t w_o,
	input  wire        wready_i,
	input  wire        bvalid_i,
	input  wire [1:0]  bresp_i,
	output logic       bready_o,
	output logic       arvalid_o,
	output axi_addr_t  ar_o,
	input  wire        arready_i,
	input  wire        rvalid_i,
	input  axi_rdata_t r_i,
	output logic       rready_o
);

	bridge_state_e state_q;
	logic          aw_done_q;
	logic          w_done_q;
	logic          aw_hs;
	logic          w_hs;
	axi_addr_t     addr_q;
	axi_wdata_t    wdata_q;

	assign req_ready_o = (state_q == BR_IDLE);

	// same address register serves both address channels
	assign aw_o = addr_q;
	assign ar_o = addr_q;
	assign w_o  = wdata_q;

	assign awvalid_o = (state_q == BR_WRITE) && !aw_done_q;
	assign wvalid_o  = (state_q == BR_WRITE) && !w_done_q;
	assign bready_o  = (state_q == BR_BRESP);
	assign arvalid_o = (state_q == BR_AREQ);
	assign rready_o  = (state_q == BR_RDATA);

	assign aw_hs = awvalid_o && awready_i;
	assign w_hs  = wvalid_o && wready_i;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			state_q     <= BR_IDLE;
			aw_done_q   <= 1'b0;
			w_done_q    <= 1'b0;
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= 1'b0;
			case (state_q)
				BR_IDLE: begin
					aw_done_q <= 1'b0;
					w_done_q  <= 1'b0;
					if (req_valid_i) begin
						state_q <= req_i.we ? BR_WRITE : BR_AREQ;
					end
				end
				BR_WRITE: begin
					// AW and W may finish in either order
					aw_done_q <= aw_done_q || aw_hs;
					w_done_q  <= w_done_q || w_hs;
					if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
						state_q <= BR_BRESP;
					end
				end
				BR_BRESP: begin
					if (bvalid_i) begin
						state_q     <= BR_IDLE;
						rsp_valid_o <= 1'b1;
					end
				end
				BR_AREQ: begin
					if (arready_i) begin
						state_q <= BR_RDATA;
					end
				end
				BR_RDATA: begin
					if (rvalid_i) begin
						state_q     <= BR_IDLE;
						rsp_valid_o <= 1'b1;
					end
				end
				default: begin
					state_q <= BR_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (req_valid_i && req_ready_o) begin
			addr_q.addr   <= req_i.addr;
			addr_q.size   <= req_i.size;
			wdata_q.data  <= req_i.wdata;
			wdata_q.strb  <= req_i.wstrb;
		end
		if (bready_o && bvalid_i) begin
			rsp_o.rdata <= '0;
			rsp_o.err   <= (bresp_i != `AXI_RESP_OKAY);
		end else if (rready_o && rvalid_i) begin
			rsp_o.rdata <= r_i.data;
			rsp_o.err   <= (r_i.resp != `AXI_RESP_OKAY);
		end
	end

endmodule

`default_nettype wire

/* design/clint_timer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bus_params.svh"

module clint_timer
	import bus_pkg::*;
(
	input  wire      clock,
	input  wire      rst_i,
	input  wire      req_valid_i,
	input  bus_req_t req_i,
	output logic     req_ready_o,
	output logic     rsp_valid_o,
	output bus_rsp_t rsp_o
);

	logic [63:0]            mtime_q;
	logic [`BUS_ADDR_W-1:0] offset;

	assign offset = req_i.addr - `CLINT_BASE;

	// one request at a time, busy while the answer is out
	assign req_ready_o = !rsp_valid_o;

	// free-running, read only from the bus
	always_ff @(posedge clock) begin
		if (rst_i) begin
			mtime_q <= 64'd0;
		end else begin
			mtime_q <= mtime_q + 64'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (rst_i) begin
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= req_valid_i && req_ready_o;
		end
	end

	// sample mtime as seen at the accepting edge
	always_ff @(posedge clock) begin
		if (req_valid_i && req_ready_o) begin
			rsp_o.rdata <= '0;
			rsp_o.err   <= 1'b1;
			if (!req_i.we && offset == `CLINT_MTIME_LO) begin
				rsp_o.rdata <= mtime_q[31:0];
				rsp_o.err   <= 1'b0;
			end else if (!req_i.we && offset == `CLINT_MTIME_HI) begin
				rsp_o.rdata <= mtime_q[63:32];
				rsp_o.err   <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* design/bus_xbar.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bus_params.svh"

module bus_xbar
	import bus_pkg::*;
(
	input  wire      clock,
	input  wire      rst_i,
	input  wire      req_valid_i,
	input  bus_req_t req_i,
	output logic     req_ready_o,
	output logic     rsp_valid_o,
	output bus_rsp_t rsp_o,
	output logic     clint_valid_o,
	input  wire      clint_ready_i,
	input  wire      clint_rsp_valid_i,
	input  bus_rsp_t clint_rsp_i,
	output logic     axi_valid_o,
	input  wire      axi_ready_i,
	input  wire      axi_rsp_valid_i,
	input  bus_rsp_t axi_rsp_i
);

	logic    hit_clint;
	target_e tgt_q;

	// address window decode
	assign hit_clint = (req_i.addr >= `CLINT_BASE) &&
		(req_i.addr < (`CLINT_BASE + `CLINT_SPAN));

	assign clint_valid_o = req_valid_i && hit_clint;
	assign axi_valid_o   = req_valid_i && !hit_clint;
	assign req_ready_o   = hit_clint ? clint_ready_i : axi_ready_i;

	// remember who owns the transaction in flight
	always_ff @(posedge clock) begin
		if (rst_i) begin
			tgt_q <= TGT_AXI;
		end else if (req_valid_i && req_ready_o) begin
			tgt_q <= hit_clint ? TGT_CLINT : TGT_AXI;
		end
	end

	assign rsp_valid_o = (tgt_q == TGT_CLINT) ? clint_rsp_valid_i : axi_rsp_valid_i;
	assign rsp_o       = (tgt_q == TGT_CLINT) ? clint_rsp_i : axi_rsp_i;

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter
	import bus_pkg::*;
(
	input  wire      clock,
	input  wire      rst_i,
	input  wire      inst_valid_i,
	input  bus_req_t inst_req_i,
	output logic     inst_ready_o,
	output logic     inst_rsp_valid_o,
	input  wire      data_valid_i,
	input  bus_req_t data_req_i,
	output logic     data_ready_o,
	output logic     data_rsp_valid_o,
	output bus_rsp_t rsp_o,
	output logic     xreq_valid_o,
	output bus_req_t xreq_o,
	input  wire      xreq_ready_i,
	input  wire      xrsp_valid_i,
	input  bus_rsp_t xrsp_i
);

	arb_state_e state_q;
	logic       sent_q;
	bus_req_t   req_q;

	// data port wins when both are valid
	assign data_ready_o = (state_q == ARB_IDLE);
	assign inst_ready_o = (state_q == ARB_IDLE) && !data_valid_i;

	assign xreq_valid_o = (state_q != ARB_IDLE) && !sent_q;
	assign xreq_o       = req_q;

	// payload is shared, only the owner sees the pulse
	assign rsp_o            = xrsp_i;
	assign inst_rsp_valid_o = (state_q == ARB_INST) && xrsp_valid_i;
	assign data_rsp_valid_o = (state_q == ARB_DATA) && xrsp_valid_i;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			state_q <= ARB_IDLE;
			sent_q  <= 1'b0;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (data_valid_i) begin
						state_q <= ARB_DATA;
					end else if (inst_valid_i) begin
						state_q <= ARB_INST;
					end
				end
				default: begin
					if (xreq_valid_o && xreq_ready_i) begin
						sent_q <= 1'b1;
					end
					// back to idle once the owner has its response
					if (xrsp_valid_i) begin
						state_q <= ARB_IDLE;
						sent_q  <= 1'b0;
					end
				end
			endcase
		end
	end

	// capture the winning request
	always_ff @(posedge clock) begin
		if (data_ready_o && data_valid_i) begin
			req_q <= data_req_i;
		end else if (inst_ready_o && inst_valid_i) begin
			req_q <= inst_req_i;
		end
	end

endmodule

`default_nettype wire

/* design/bus_pkg.sv */
`default_nettype none
`include "bus_params.svh"

package bus_pkg;

	// AXI size encoding
	typedef enum logic [2:0] {
		SZ_BYTE = 3'd0,
		SZ_HALF = 3'd1,
		SZ_WORD = 3'd2
	} xfer_size_e;

	typedef struct packed {
		logic [`BUS_ADDR_W-1:0] addr;
		logic [`BUS_DATA_W-1:0] wdata;
		logic [`BUS_STRB_W-1:0] wstrb;
		xfer_size_e             size;
		logic                   we;
	} bus_req_t;

	typedef struct packed {
		logic [`BUS_DATA_W-1:0] rdata;
		logic                   err;
	} bus_rsp_t;

	// shared by AW and AR
	typedef struct packed {
		logic [`BUS_ADDR_W-1:0] addr;
		xfer_size_e             size;
	} axi_addr_t;

	typedef struct packed {
		logic [`BUS_DATA_W-1:0] data;
		logic [`BUS_STRB_W-1:0] strb;
	} axi_wdata_t;

	typedef struct packed {
		logic [`BUS_DATA_W-1:0] data;
		logic [1:0]             resp;
	} axi_rdata_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_INST,
		ARB_DATA
	} arb_state_e;

	typedef enum logic [2:0] {
		BR_IDLE,
		BR_WRITE,
		BR_BRESP,
		BR_AREQ,
		BR_RDATA
	} bridge_state_e;

	typedef enum logic {
		TGT_AXI,
		TGT_CLINT
	} target_e;

endpackage

`default_nettype wire

/* design/bus_params.svh */
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// bus widths, fixed by the ISA
`define BUS_ADDR_W 32
`define BUS_DATA_W 32
`define BUS_STRB_W 4

// core-local timer window
`define CLINT_BASE 32'h0200_0000
`define CLINT_SPAN 32'h0001_0000

// register offsets inside the window
`define CLINT_MTIME_LO 32'h0000_BFF8
`define CLINT_MTIME_HI 32'h0000_BFFC

// AXI response codes
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif
